//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    typedef logic [7:0]         pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [23:0] acc_t;
    typedef logic [7:0]         addr_t;
    typedef logic [7:0]         byte_t;

    // Sequencer state, also shown on the LEDs
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_LOAD,
        PH_COMPUTE,
        PH_SEND
    } phase_e;

    // ASCII L and C
    typedef enum logic [7:0] {
        CMD_LOAD    = 8'h4C,
        CMD_COMPUTE = 8'h43
    } cmd_e;

    localparam int IMG_DIM  = 12;
    localparam int KER_DIM  = 5;
    localparam int CONV_DIM = 8;
    localparam int POOL_DIM = 4;
    localparam int KER_TAPS = 25;

    // Feature memory map
    localparam addr_t IMG_BASE     = 8'd0;
    localparam addr_t KERNEL_BASE  = 8'd144;
    localparam addr_t BIAS_ADDR    = 8'd169;
    localparam addr_t RESULT_BASE  = 8'd170;
    localparam int    MEM_DEPTH    = 186;
    localparam addr_t LOAD_BYTES   = 8'd170;
    localparam addr_t RESULT_BYTES = 8'd16;

    localparam int CLKS_PER_BIT = 16;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;

    localparam baud_cnt_t BIT_END      = baud_cnt_t'(CLKS_PER_BIT - 1);
    localparam baud_cnt_t HALF_BIT_END = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);

endpackage

`default_nettype wire

//--- cnn_testdata.txt
// Marker byte, then its data: a0 = load (144 image, 25 kernel, 1 bias), c0 = compute
// (16 expected pooled bytes), e0 = one raw byte sent as is, ff = end of data
a0 // load case 1, pixel = 16*row + col
00 01 02 03 04 05 06 07 08 09 0a 0b 10 11 12 13 14 15 16 17 18 19 1a 1b
20 21 22 23 24 25 26 27 28 29 2a 2b 30 31 32 33 34 35 36 37 38 39 3a 3b
40 41 42 43 44 45 46 47 48 49 4a 4b 50 51 52 53 54 55 56 57 58 59 5a 5b
60 61 62 63 64 65 66 67 68 69 6a 6b 70 71 72 73 74 75 76 77 78 79 7a 7b
80 81 82 83 84 85 86 87 88 89 8a 8b 90 91 92 93 94 95 96 97 98 99 9a 9b
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb
00 fb 00 00 00 fe 00 00 00 00 00 00 00 00 00 00 00 00 00 00 01 00 00 00 03 1d
c0 // compute case 1, clips at 255 and at 0
ff fe f8 f2 a4 9e 98 92 44 3e 38 32 00 00 00 00
a0 // load case 2, pixel = 16*col + row, negative bias
00 10 20 30 40 50 60 70 80 90 a0 b0 01 11 21 31 41 51 61 71 81 91 a1 b1
02 12 22 32 42 52 62 72 82 92 a2 b2 03 13 23 33 43 53 63 73 83 93 a3 b3
04 14 24 34 44 54 64 74 84 94 a4 b4 05 15 25 35 45 55 65 75 85 95 a5 b5
06 16 26 36 46 56 66 76 86 96 a6 b6 07 17 27 37 47 57 67 77 87 97 a7 b7
08 18 28 38 48 58 68 78 88 98 a8 b8 09 19 29 39 49 59 69 79 89 99 a9 b9
0a 1a 2a 3a 4a 5a 6a 7a 8a 9a aa ba 0b 1b 2b 3b 4b 5b 6b 7b 8b 9b ab bb
00 00 03 00 00 00 ff 00 00 00 ff 00 00 00 00 00 00 00 00 01 00 00 00 00 00 9c
c0 // compute case 2
4e 8e ce ff 52 92 d2 ff 56 96 d6 ff 5a 9a da ff
e0 5a // unknown command byte
c0 // compute again with no reload
4e 8e ce ff 52 92 d2 ff 56 96 d6 ff 5a 9a da ff
ff

//--- cnn_top.sv
`default_nettype none

module cnn_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output logic            tx,
    output cnn_pkg::phase_e state_led
);

    cnn_pkg::byte_t  rx_byte;
    logic            rx_valid;
    cnn_pkg::byte_t  tx_byte;
    logic            tx_start;
    logic            tx_busy;
    logic            conv_start;
    logic            conv_valid;
    cnn_pkg::pixel_t conv_value;
    logic            pool_done;

    mem_port_if host_port ();
    mem_port_if conv_port ();
    mem_port_if pool_port ();

    uart_rx u_uart_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_tx u_uart_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    feature_mem u_feature_mem (
        .clk       (clk),
        .host_port (host_port),
        .conv_port (conv_port),
        .pool_port (pool_port)
    );

    conv_engine u_conv_engine (
        .clk        (clk),
        .reset      (reset),
        .start      (conv_start),
        .mem        (conv_port),
        .conv_valid (conv_valid),
        .conv_value (conv_value)
    );

    maxpool_unit u_maxpool_unit (
        .clk        (clk),
        .reset      (reset),
        .conv_valid (conv_valid),
        .conv_value (conv_value),
        .mem        (pool_port),
        .pool_done  (pool_done)
    );

    host_link u_host_link (
        .clk       (clk),
        .reset     (reset),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .tx_busy   (tx_busy),
        .pool_done (pool_done),
        .mem       (host_port),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .start     (conv_start),
        .phase     (state_led)
    );

endmodule

`default_nettype wire

//--- conv_engine.sv
`default_nettype none

module conv_engine (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    mem_port_if.requester   mem,
    output logic            conv_valid,
    output cnn_pkg::pixel_t conv_value
);

    typedef enum logic [1:0] {
        CV_IDLE,
        CV_KERNEL,
        CV_IMAGE
    } conv_state_e;

    conv_state_e        state;
    logic [4:0]         tap;
    logic [2:0]         kx;
    logic [2:0]         ky;
    logic [2:0]         ox;
    logic [2:0]         oy;
    logic               last_tap;
    cnn_pkg::weight_t   kernel [cnn_pkg::KER_TAPS];
    cnn_pkg::weight_t   bias;
    logic               kernel_rd_d;
    logic               image_rd_d;
    logic [4:0]         tap_d;
    logic               first_d;
    logic               last_d;
    logic signed [16:0] product;
    cnn_pkg::acc_t      acc;
    cnn_pkg::acc_t      biased;
    logic               acc_done;
    cnn_pkg::pixel_t    clipped;

    assign last_tap = (kx == 3'(cnn_pkg::KER_DIM - 1)) && (ky == 3'(cnn_pkg::KER_DIM - 1));

    // Kernel taps then bias, afterwards the image window
    always_comb begin
        if (state == CV_KERNEL) begin
            mem.addr = (tap == 5'(cnn_pkg::KER_TAPS)) ? cnn_pkg::BIAS_ADDR
                     : cnn_pkg::KERNEL_BASE + cnn_pkg::addr_t'(tap);
        end else begin
            mem.addr = cnn_pkg::IMG_BASE
                     + cnn_pkg::addr_t'((oy + ky) * cnn_pkg::IMG_DIM + ox + kx);
        end
    end

    assign mem.wr_en = 1'b0;
    assign mem.wdata = '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= CV_IDLE;
            tap   <= '0;
            kx    <= '0;
            ky    <= '0;
            ox    <= '0;
            oy    <= '0;
        end else begin
            case (state)
                CV_IDLE: begin
                    tap <= '0;
                    if (start) begin
                        state <= CV_KERNEL;
                    end
                end
                CV_KERNEL: begin
                    if (tap == 5'(cnn_pkg::KER_TAPS)) begin
                        tap   <= '0;
                        kx    <= '0;
                        ky    <= '0;
                        ox    <= '0;
                        oy    <= '0;
                        state <= CV_IMAGE;
                    end else begin
                        tap <= tap + 1'b1;
                    end
                end
                CV_IMAGE: begin
                    tap <= tap + 1'b1;
                    if (kx == 3'(cnn_pkg::KER_DIM - 1)) begin
                        kx <= '0;
                        ky <= ky + 1'b1;
                    end else begin
                        kx <= kx + 1'b1;
                    end
                    // Next output position in raster order
                    if (last_tap) begin
                        tap <= '0;
                        ky  <= '0;
                        if (ox == 3'(cnn_pkg::CONV_DIM - 1)) begin
                            ox <= '0;
                            oy <= oy + 1'b1;
                            if (oy == 3'(cnn_pkg::CONV_DIM - 1)) begin
                                state <= CV_IDLE;
                            end
                        end else begin
                            ox <= ox + 1'b1;
                        end
                    end
                end
                default: state <= CV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            kernel_rd_d <= 1'b0;
            image_rd_d  <= 1'b0;
            acc_done    <= 1'b0;
            conv_valid  <= 1'b0;
        end else begin
            kernel_rd_d <= (state == CV_KERNEL);
            image_rd_d  <= (state == CV_IMAGE);
            acc_done    <= image_rd_d && last_d;
            conv_valid  <= acc_done;
        end
    end

    // Pixel is unsigned, so it gets a zero sign bit
    assign product = $signed({1'b0, mem.rdata}) * kernel[tap_d];

    assign biased = acc + cnn_pkg::acc_t'(bias);

    always_comb begin
        if (biased[23]) begin
            clipped = '0;
        end else if (|biased[22:8]) begin
            clipped = 8'hFF;
        end else begin
            clipped = biased[7:0];
        end
    end

    // First tap restarts the sum, so outputs can overlap in the pipe
    always_ff @(posedge clk) begin
        tap_d   <= tap;
        first_d <= (tap == '0);
        last_d  <= last_tap;
        if (kernel_rd_d) begin
            if (tap_d == 5'(cnn_pkg::KER_TAPS)) begin
                bias <= mem.rdata;
            end else begin
                kernel[tap_d] <= mem.rdata;
            end
        end
        if (image_rd_d) begin
            acc <= first_d ? cnn_pkg::acc_t'(product) : acc + cnn_pkg::acc_t'(product);
        end
        if (acc_done) begin
            conv_value <= clipped;
        end
    end

endmodule

`default_nettype wire

//--- feature_mem.sv
`default_nettype none

module feature_mem (
    input  logic       clk,
    mem_port_if.memory host_port,
    mem_port_if.memory conv_port,
    mem_port_if.memory pool_port
);

    cnn_pkg::byte_t mem [cnn_pkg::MEM_DEPTH];

    // Host and pool ports are never active in the same phase
    always_ff @(posedge clk) begin
        if (host_port.wr_en) begin
            mem[host_port.addr] <= host_port.wdata;
        end
        if (pool_port.wr_en) begin
            mem[pool_port.addr] <= pool_port.wdata;
        end
        host_port.rdata <= mem[host_port.addr];
        conv_port.rdata <= mem[conv_port.addr];
    end

    // Write-only port
    assign pool_port.rdata = '0;

endmodule

`default_nettype wire

//--- filelist.f
cnn_pkg.sv
mem_port_if.sv
uart_rx.sv
uart_tx.sv
feature_mem.sv
conv_engine.sv
maxpool_unit.sv
host_link.sv
cnn_top.sv
tb_cnn.sv

//--- host_link.sv
`default_nettype none

module host_link (
    input  logic            clk,
    input  logic            reset,
    input  cnn_pkg::byte_t  rx_byte,
    input  logic            rx_valid,
    input  logic            tx_busy,
    input  logic            pool_done,
    mem_port_if.requester   mem,
    output cnn_pkg::byte_t  tx_byte,
    output logic            tx_start,
    output logic            start,
    output cnn_pkg::phase_e phase
);

    // Byte count for both load and send
    cnn_pkg::addr_t cnt;
    logic           rdata_ok;

    assign start = (phase == cnn_pkg::PH_IDLE) && rx_valid
                   && (rx_byte == cnn_pkg::CMD_COMPUTE);

    assign mem.addr  = (phase == cnn_pkg::PH_SEND) ? cnn_pkg::RESULT_BASE + cnt : cnt;
    assign mem.wr_en = (phase == cnn_pkg::PH_LOAD) && rx_valid;
    assign mem.wdata = rx_byte;

    assign tx_byte  = mem.rdata;
    assign tx_start = (phase == cnn_pkg::PH_SEND) && rdata_ok && !tx_busy
                      && (cnt != cnn_pkg::RESULT_BYTES);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= cnn_pkg::PH_IDLE;
            cnt      <= '0;
            rdata_ok <= 1'b0;
        end else begin
            // rdata follows the address one cycle later
            rdata_ok <= (phase == cnn_pkg::PH_SEND) && !tx_start;
            case (phase)
                cnn_pkg::PH_IDLE: begin
                    cnt <= '0;
                    if (rx_valid) begin
                        if (rx_byte == cnn_pkg::CMD_LOAD) begin
                            phase <= cnn_pkg::PH_LOAD;
                        end else if (rx_byte == cnn_pkg::CMD_COMPUTE) begin
                            phase <= cnn_pkg::PH_COMPUTE;
                        end
                    end
                end
                cnn_pkg::PH_LOAD: begin
                    if (rx_valid) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == cnn_pkg::LOAD_BYTES - 8'd1) begin
                            phase <= cnn_pkg::PH_IDLE;
                        end
                    end
                end
                cnn_pkg::PH_COMPUTE: begin
                    if (pool_done) begin
                        phase <= cnn_pkg::PH_SEND;
                    end
                end
                cnn_pkg::PH_SEND: begin
                    if (tx_start) begin
                        cnt <= cnt + 1'b1;
                    end
                    // Wait out the last stop bit
                    if (cnt == cnn_pkg::RESULT_BYTES && !tx_busy) begin
                        phase <= cnn_pkg::PH_IDLE;
                    end
                end
                default: phase <= cnn_pkg::PH_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- maxpool_unit.sv
`default_nettype none

module maxpool_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            conv_valid,
    input  cnn_pkg::pixel_t conv_value,
    mem_port_if.requester   mem,
    output logic            pool_done
);

    logic [2:0]      row;
    logic [2:0]      col;
    logic            pair_end;
    cnn_pkg::pixel_t pair_first;
    cnn_pkg::pixel_t pair_max;
    cnn_pkg::pixel_t pool_max;
    cnn_pkg::pixel_t line_buf [cnn_pkg::POOL_DIM];

    assign pair_end = conv_valid && col[0];
    assign pair_max = (conv_value > pair_first) ? conv_value : pair_first;
    assign pool_max = (pair_max > line_buf[col[2:1]]) ? pair_max : line_buf[col[2:1]];

    // Odd row closes a 2x2 block
    assign mem.wr_en = pair_end && row[0];
    assign mem.wdata = pool_max;
    assign mem.addr  = cnn_pkg::RESULT_BASE
                     + cnn_pkg::addr_t'(row[2:1] * cnn_pkg::POOL_DIM + col[2:1]);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            row       <= '0;
            col       <= '0;
            pool_done <= 1'b0;
        end else begin
            pool_done <= mem.wr_en && (row == 3'(cnn_pkg::CONV_DIM - 1))
                         && (col == 3'(cnn_pkg::CONV_DIM - 1));
            if (conv_valid) begin
                if (col == 3'(cnn_pkg::CONV_DIM - 1)) begin
                    col <= '0;
                    // Wraps after the last row, ready for the next map
                    row <= (row == 3'(cnn_pkg::CONV_DIM - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (conv_valid && !col[0]) begin
            pair_first <= conv_value;
        end
        if (pair_end && !row[0]) begin
            line_buf[col[2:1]] <= pair_max;
        end
    end

endmodule

`default_nettype wire

//--- mem_port_if.sv
`default_nettype none

interface mem_port_if;

    cnn_pkg::addr_t addr;
    logic           wr_en;
    cnn_pkg::byte_t wdata;
    cnn_pkg::byte_t rdata;

    modport requester (
        output addr,
        output wr_en,
        output wdata,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wr_en,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_cnn -f filelist.f

sim_output="$(./obj_dir/Vtb_cnn)"
echo "${sim_output}"

if grep -qx "sim passed" <<< "${sim_output}"; then
    exit 0
fi
exit 1

//--- tb_cnn.sv
`default_nettype none

module tb_cnn;

    localparam int STIM_DEPTH    = 512;
    localparam int LOAD_LEN      = 170;
    localparam int RESULT_LEN    = 16;
    localparam int START_TIMEOUT = 4000;
    localparam int IDLE_TIMEOUT  = 200;

    // ASCII L and C
    localparam cnn_pkg::byte_t LOAD_CMD    = 8'h4C;
    localparam cnn_pkg::byte_t COMPUTE_CMD = 8'h43;

    // Case markers in the data file
    localparam cnn_pkg::byte_t MARK_LOAD    = 8'hA0;
    localparam cnn_pkg::byte_t MARK_COMPUTE = 8'hC0;
    localparam cnn_pkg::byte_t MARK_RAW     = 8'hE0;
    localparam cnn_pkg::byte_t MARK_END     = 8'hFF;

    logic            clk;
    logic            reset;
    logic            rx;
    logic            tx;
    cnn_pkg::phase_e state_led;

    cnn_pkg::byte_t stim [0:STIM_DEPTH-1];
    int             value_errors;
    int             other_errors;

    cnn_top u_cnn_top (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .tx        (tx),
        .state_led (state_led)
    );

    always #5 clk = ~clk;

    task automatic check_pixel(input int index, input cnn_pkg::pixel_t expected,
                               input cnn_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: result byte %0d expected %02h got %02h",
                     $time, index, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_phase(input cnn_pkg::phase_e expected, input cnn_pkg::phase_e actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: state_led expected %s got %s",
                     $time, expected.name(), actual.name());
            value_errors++;
        end
    endtask

    task automatic check_level(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual);
            value_errors++;
        end
    endtask

    // 8N1 frame with the LSB first
    task automatic send_byte(input cnn_pkg::byte_t value);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (cnn_pkg::CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic receive_byte(output cnn_pkg::byte_t value, output logic ok);
        int waited;
        int i;
        value  = '0;
        ok     = 1'b0;
        waited = 0;
        @(negedge clk);
        while (tx !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("timeout waiting for start bit");
            other_errors++;
        end else begin
            // Move to mid start bit and sample once per bit period
            repeat (cnn_pkg::CLKS_PER_BIT / 2) @(negedge clk);
            for (i = 0; i < 8; i++) begin
                repeat (cnn_pkg::CLKS_PER_BIT) @(negedge clk);
                value[i] = tx;
            end
            repeat (cnn_pkg::CLKS_PER_BIT) @(negedge clk);
            if (tx !== 1'b1) begin
                $display("stop bit on tx was low at %0t", $time);
                other_errors++;
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (state_led != cnn_pkg::PH_IDLE && waited < IDLE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_phase(cnn_pkg::PH_IDLE, state_led);
    endtask

    // Expected bytes start at stim[first]
    task automatic run_compute(input int first);
        cnn_pkg::byte_t got;
        logic           ok;
        int             k;
        k  = 0;
        ok = 1'b1;
        send_byte(COMPUTE_CMD);
        while (ok && k < RESULT_LEN) begin
            receive_byte(got, ok);
            if (ok) begin
                check_pixel(k, cnn_pkg::pixel_t'(stim[first + k]), cnn_pkg::pixel_t'(got));
            end
            k++;
        end
        wait_idle();
    endtask

    initial begin
        int             pos;
        int             k;
        int             computes;
        logic           parsing;
        cnn_pkg::byte_t marker;
        clk          = 1'b0;
        reset        = 1'b1;
        rx           = 1'b1;
        value_errors = 0;
        other_errors = 0;
        computes     = 0;
        pos          = 0;
        parsing      = 1'b1;
        $readmemh("cnn_testdata.txt", stim);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_phase(cnn_pkg::PH_IDLE, state_led);
        check_level("tx after reset", 1'b1, tx);
        while (parsing) begin
            if (pos >= STIM_DEPTH) begin
                $display("test data has no end marker");
                other_errors++;
                parsing = 1'b0;
            end else begin
                marker = stim[pos];
                pos++;
                case (marker)
                    MARK_LOAD: begin
                        send_byte(LOAD_CMD);
                        for (k = 0; k < LOAD_LEN; k++) begin
                            send_byte(stim[pos + k]);
                        end
                        pos += LOAD_LEN;
                    end
                    MARK_COMPUTE: begin
                        run_compute(pos);
                        pos += RESULT_LEN;
                        computes++;
                    end
                    MARK_RAW: begin
                        send_byte(stim[pos]);
                        pos++;
                        // Unknown command leaves the sequencer idle
                        @(negedge clk);
                        check_phase(cnn_pkg::PH_IDLE, state_led);
                    end
                    MARK_END: parsing = 1'b0;
                    default: begin
                        $display("unknown marker %02h in test data at word %0d", marker, pos - 1);
                        other_errors++;
                        parsing = 1'b0;
                    end
                endcase
            end
        end
        if (computes == 0) begin
            $display("no compute case found in test data");
            other_errors++;
        end
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`default_nettype none

module uart_rx (
    input  logic           clk,
    input  logic           reset,
    input  logic           rx,
    output cnn_pkg::byte_t rx_byte,
    output logic           rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e          state;
    cnn_pkg::baud_cnt_t clk_cnt;
    logic [2:0]         bit_idx;
    logic               rx_meta;
    logic               rx_sync;
    logic               sample_data;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign sample_data = (state == RX_DATA) && (clk_cnt == cnn_pkg::BIT_END);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == cnn_pkg::HALF_BIT_END) begin
                        clk_cnt <= '0;
                        // Line back high at mid start bit, treat as a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == cnn_pkg::BIT_END) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == cnn_pkg::BIT_END) begin
                        // Framing error drops the byte
                        rx_valid <= rx_sync;
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (sample_data) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none

module uart_tx (
    input  logic           clk,
    input  logic           reset,
    input  cnn_pkg::byte_t tx_byte,
    input  logic           tx_start,
    output logic           tx,
    output logic           tx_busy
);

    logic [9:0]         shift_reg;
    logic [3:0]         bit_cnt;
    cnn_pkg::baud_cnt_t clk_cnt;

    // Frame is start bit, 8 data bits LSB first, stop bit
    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            shift_reg <= {1'b1, tx_byte, 1'b0};
        end else if (tx_busy && clk_cnt == cnn_pkg::BIT_END) begin
            shift_reg <= {1'b1, shift_reg[9:1]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= tx_start;
        end else if (clk_cnt == cnn_pkg::BIT_END) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            // End of stop bit
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign tx = tx_busy ? shift_reg[0] : 1'b1;

endmodule

`default_nettype wire
